// File: src/filterPkg.sv
`default_nettype none

package filterPkg;

    // Fraction bits of the stored tables
    localparam int CoeffBias = 20;
    localparam int CoeffWidth = 32;
    // Table sizes, upper bounds for numChannels and osr
    localparam int MaxChannels = 4;
    localparam int MaxOsr = 16;
    // Internal fixed-point word
    localparam int IntBits = 9;
    localparam int MaxFrac = 16;
    localparam int MaxWord = IntBits + MaxFrac + 1;
    localparam int ProdWidth = 2 * MaxWord;
    // Input register to pcmOut, in clkDS cycles
    localparam int PipeLatency = 5;

    typedef logic signed [CoeffWidth-1:0] coeffT;
    typedef logic signed [MaxWord-1:0] wordT;

    typedef struct packed {
        wordT re;
        wordT im;
    } cplxT;

    // Forward input coefficients, one row per channel, indexed by bit age
    localparam coeffT coeffFr [MaxChannels][MaxOsr] = '{
        '{21840, 20110, 18370, 16620, 14890, 13160, 11450, 9770,
          8120, 6510, 4950, 3450, 2010, 640, -660, -1880},
        '{18920, 15270, 11240, 6990, 2690, -1500, -5420, -8950,
          -11980, -14430, -16230, -17350, -17760, -17480, -16530, -14960},
        '{15310, 8620, 1490, -5420, -11460, -16050, -18800, -19490,
          -18110, -14850, -10080, -4310, 1820, 7660, 12560, 16000},
        '{12440, 1170, -9720, -17470, -20460, -17940, -10520, -140,
          10280, 17940, 20870, 18240, 10890, 670, -9710, -17440}
    };

    localparam coeffT coeffFi [MaxChannels][MaxOsr] = '{
        '{1100, 2180, 3220, 4200, 5110, 5950, 6700, 7360,
          7920, 8380, 8730, 8980, 9120, 9150, 9080, 8910},
        '{2870, 5590, 7980, 9900, 11230, 11890, 11850, 11120,
          9770, 7880, 5570, 2980, 260, -2460, -5030, -7310},
        '{4720, 8930, 11920, 13210, 12600, 10180, 6310, 1580,
          -3330, -7770, -11120, -12930, -12980, -11280, -8090, -3850},
        '{6210, 10850, 12680, 11210, 6850, 680, -5600, -10410,
          -12520, -11320, -7120, -1100, 5110, 9970, 12380, 11680}
    };

    // Channel poles, magnitude just under one
    localparam coeffT poleR [MaxChannels] = '{1031560, 1021250, 986720, 906410};
    localparam coeffT poleI [MaxChannels] = '{51620, 154350, 305230, 495180};

    // Output weights
    localparam coeffT weightR [MaxChannels] = '{2516582, 1992294, -1677722, 1258291};
    localparam coeffT weightI [MaxChannels] = '{-629146, 524288, 1153434, -1363149};

    // Pole of one channel raised to osr, returned at fracBits
    function automatic cplxT poleToOsr(int ch, int osr, int fracBits);
        logic signed [63:0] accR;
        logic signed [63:0] accI;
        logic signed [127:0] prodR;
        logic signed [127:0] prodI;
        cplxT result;
        accR = poleR[ch];
        accI = poleI[ch];
        for (int k = 1; k < osr; k++) begin
            prodR = accR * poleR[ch] - accI * poleI[ch];
            prodI = accI * poleR[ch] + accR * poleI[ch];
            // Truncate back to table precision every step
            accR = 64'(prodR >>> CoeffBias);
            accI = 64'(prodI >>> CoeffBias);
        end
        result.re = wordT'(accR >>> (CoeffBias - fracBits));
        result.im = wordT'(accI >>> (CoeffBias - fracBits));
        return result;
    endfunction

endpackage

`default_nettype wire

// File: src/sampleLut.sv
`timescale 1ns/1ps
`default_nettype none

module sampleLut #(
    parameter int numChannels = 4,
    parameter int osr = 8,
    parameter int fracBits = 14
) (
    input wire clkDS,
    input wire rst,
    input wire [osr-1:0] sampleBits,
    output filterPkg::cplxT lutOut [numChannels]
);
    import filterPkg::*;

    typedef wordT rowT [osr];

    // Coefficient row of one channel, moved from CoeffBias to fracBits
    function automatic rowT scaledRow(int ch, bit imagPart);
        rowT row;
        for (int j = 0; j < osr; j++) begin
            if (imagPart) begin
                row[j] = wordT'(coeffFi[ch][j] >>> (CoeffBias - fracBits));
            end else begin
                row[j] = wordT'(coeffFr[ch][j] >>> (CoeffBias - fracBits));
            end
        end
        return row;
    endfunction

    // Captured modulator word
    logic [osr-1:0] bitsReg;

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            bitsReg <= '0;
        end else begin
            bitsReg <= sampleBits;
        end
    end

    for (genvar ch = 0; ch < numChannels; ch++) begin : gChan
        // Constant rows, fixed at elaboration
        localparam rowT RowR = scaledRow(ch, 1'b0);
        localparam rowT RowI = scaledRow(ch, 1'b1);
        cplxT lutSum;

        always_comb begin
            lutSum = '0;
            for (int j = 0; j < osr; j++) begin
                // Bit one adds, bit zero subtracts
                if (bitsReg[j]) begin
                    lutSum.re = lutSum.re + RowR[j];
                    lutSum.im = lutSum.im + RowI[j];
                end else begin
                    lutSum.re = lutSum.re - RowR[j];
                    lutSum.im = lutSum.im - RowI[j];
                end
            end
        end

        // Complex input of the channel, ready at edge 1
        always_ff @(posedge clkDS) begin
            if (!rst) begin
                lutOut[ch] <= '0;
            end else begin
                lutOut[ch] <= lutSum;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/channelRecursion.sv
`timescale 1ns/1ps
`default_nettype none

module channelRecursion #(
    parameter int numChannels = 4,
    parameter int osr = 8,
    parameter int fracBits = 14
) (
    input wire clkDS,
    input wire rst,
    input wire filterPkg::cplxT lutIn [numChannels],
    output filterPkg::cplxT stateOut [numChannels]
);
    import filterPkg::*;

    for (genvar ch = 0; ch < numChannels; ch++) begin : gChan
        // One clkDS cycle spans osr modulator steps
        localparam cplxT PolePow = poleToOsr(ch, osr, fracBits);

        // Partial products of state times pole power
        logic signed [ProdWidth-1:0] prodRR;
        logic signed [ProdWidth-1:0] prodII;
        logic signed [ProdWidth-1:0] prodRI;
        logic signed [ProdWidth-1:0] prodIR;
        cplxT nextState;

        always_comb begin
            prodRR = stateOut[ch].re * PolePow.re;
            prodII = stateOut[ch].im * PolePow.im;
            prodRI = stateOut[ch].re * PolePow.im;
            prodIR = stateOut[ch].im * PolePow.re;
            // Each product rescaled on its own before the sum
            nextState.re = wordT'(prodRR >>> fracBits)
                         - wordT'(prodII >>> fracBits)
                         + lutIn[ch].re;
            nextState.im = wordT'(prodIR >>> fracBits)
                         + wordT'(prodRI >>> fracBits)
                         + lutIn[ch].im;
        end

        // State update, ready at edge 2
        always_ff @(posedge clkDS) begin
            if (!rst) begin
                stateOut[ch] <= '0;
            end else begin
                stateOut[ch] <= nextState;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/resultCombiner.sv
`timescale 1ns/1ps
`default_nettype none

module resultCombiner #(
    parameter int numChannels = 4,
    parameter int fracBits = 14,
    parameter int outWidth = 14
) (
    input wire clkDS,
    input wire rst,
    input wire filterPkg::cplxT stateIn [numChannels],
    output logic [outWidth-1:0] pcmOut,
    output logic valid
);
    import filterPkg::*;

    // Headroom for the channel sum
    localparam int SumWidth = MaxWord + $clog2(numChannels) + 1;
    // Sum at fracBits down to outWidth-1 fraction bits
    localparam int ScaleShift = fracBits - (outWidth - 1);
    localparam logic signed [SumWidth-1:0] PcmMax = SumWidth'(2 ** (outWidth - 1) - 1);
    localparam logic signed [SumWidth-1:0] PcmMin = -PcmMax - 1;
    // Offset-binary zero
    localparam logic [outWidth-1:0] ZeroCode = {1'b1, {(outWidth - 1){1'b0}}};
    localparam int CountWidth = $clog2(PipeLatency + 1);
    localparam logic [CountWidth-1:0] FillDone = CountWidth'(PipeLatency);

    wordT weighted [numChannels];

    for (genvar ch = 0; ch < numChannels; ch++) begin : gWeight
        localparam wordT WeightR = wordT'(weightR[ch] >>> (CoeffBias - fracBits));
        localparam wordT WeightI = wordT'(weightI[ch] >>> (CoeffBias - fracBits));
        logic signed [ProdWidth:0] mixReal;

        // Real part of state times weight
        always_comb begin
            mixReal = stateIn[ch].re * WeightR - stateIn[ch].im * WeightI;
        end

        // Ready at edge 3
        always_ff @(posedge clkDS) begin
            if (!rst) begin
                weighted[ch] <= '0;
            end else begin
                weighted[ch] <= wordT'(mixReal >>> fracBits);
            end
        end
    end

    logic signed [SumWidth-1:0] sumComb;
    logic signed [SumWidth-1:0] sumReg;
    logic signed [SumWidth-1:0] scaled;
    logic [outWidth-1:0] satVal;

    always_comb begin
        sumComb = '0;
        for (int ch = 0; ch < numChannels; ch++) begin
            sumComb = sumComb + weighted[ch];
        end
    end

    // Channel sum, ready at edge 4
    always_ff @(posedge clkDS) begin
        if (!rst) begin
            sumReg <= '0;
        end else begin
            sumReg <= sumComb;
        end
    end

    // Scale, then clip to the signed output range
    always_comb begin
        scaled = sumReg >>> ScaleShift;
        if (scaled > PcmMax) begin
            satVal = PcmMax[outWidth-1:0];
        end else if (scaled < PcmMin) begin
            satVal = PcmMin[outWidth-1:0];
        end else begin
            satVal = scaled[outWidth-1:0];
        end
    end

    // Two's complement to offset binary, ready at edge 5
    always_ff @(posedge clkDS) begin
        if (!rst) begin
            pcmOut <= ZeroCode;
        end else begin
            pcmOut <= {~satVal[outWidth-1], satVal[outWidth-2:0]};
        end
    end

    // Warm-up count, holds once the pipeline is full
    logic [CountWidth-1:0] fillCount;

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            fillCount <= '0;
        end else if (fillCount != FillDone) begin
            fillCount <= fillCount + 1'b1;
        end
    end

    assign valid = (fillCount == FillDone);

endmodule

`default_nettype wire

// File: src/reconFilterTop.sv
`timescale 1ns/1ps
`default_nettype none

module reconFilterTop #(
    parameter int numChannels = 4,
    parameter int osr = 8,
    parameter int fracBits = 14,
    parameter int outWidth = 14
) (
    input wire clkDS,
    input wire rst,
    input wire [osr-1:0] sampleBits,
    output logic [outWidth-1:0] pcmOut,
    output logic valid
);
    import filterPkg::*;

    // Per-channel complex lookup sums
    cplxT lutOut [numChannels];
    // Per-channel recursion states
    cplxT stateOut [numChannels];

    // Bit word to complex input
    sampleLut #(
        .numChannels(numChannels),
        .osr(osr),
        .fracBits(fracBits)
    ) lutInst (
        .clkDS(clkDS),
        .rst(rst),
        .sampleBits(sampleBits),
        .lutOut(lutOut)
    );

    // First-order complex recursions
    channelRecursion #(
        .numChannels(numChannels),
        .osr(osr),
        .fracBits(fracBits)
    ) recursionInst (
        .clkDS(clkDS),
        .rst(rst),
        .lutIn(lutOut),
        .stateOut(stateOut)
    );

    // Weighting, sum and PCM formatting
    resultCombiner #(
        .numChannels(numChannels),
        .fracBits(fracBits),
        .outWidth(outWidth)
    ) combinerInst (
        .clkDS(clkDS),
        .rst(rst),
        .stateIn(stateOut),
        .pcmOut(pcmOut),
        .valid(valid)
    );

endmodule

`default_nettype wire

// File: tests/filterChecker.sv
`timescale 1ns/1ps
`default_nettype none

module filterChecker #(
    parameter int numChannels = 4,
    parameter int osr = 8,
    parameter int fracBits = 14,
    parameter int outWidth = 14
) (
    input wire clkDS,
    input wire rst,
    input wire [osr-1:0] sampleBits,
    input wire [outWidth-1:0] pcmOut,
    input wire valid,
    input wire [2:0] testId,
    output int errorCount,
    output int checkCount,
    output int satCount
);
    import filterPkg::*;

    // Sample word to pcmOut in clkDS edges
    localparam int Latency = 5;
    localparam int Shift = CoeffBias - fracBits;
    localparam longint OutMax = 2 ** (outWidth - 1) - 1;
    localparam longint OutMin = -(2 ** (outWidth - 1));
    localparam logic [outWidth-1:0] ZeroCode = outWidth'(2 ** (outWidth - 1));

    // Model recursion states per channel
    longint stateR [numChannels];
    longint stateI [numChannels];
    // Word held in the input register
    logic [osr-1:0] heldBits;
    logic [outWidth-1:0] expQ [$];
    logic [outWidth-1:0] expPcm;
    logic expValid;
    logic [2:0] curTest;
    bit armed;

    // Low MaxWord bits sign extended
    function automatic longint wrapWord(longint v);
        logic signed [MaxWord-1:0] w;
        w = v[MaxWord-1:0];
        return longint'(w);
    endfunction

    // Coefficient added for a one and subtracted for a zero
    function automatic longint lookup(int ch, logic [osr-1:0] bits, bit imagPart);
        longint c;
        longint sum;
        sum = 0;
        for (int j = 0; j < osr; j++) begin
            c = imagPart ? longint'(coeffFi[ch][j]) : longint'(coeffFr[ch][j]);
            c = c >>> Shift;
            sum = bits[j] ? sum + c : sum - c;
        end
        return sum;
    endfunction

    // Weighting, channel sum, scaling and offset binary of the model states
    function automatic logic [outWidth-1:0] outputCode();
        longint wr;
        longint wi;
        longint sum;
        longint scaled;
        sum = 0;
        for (int ch = 0; ch < numChannels; ch++) begin
            wr = longint'(weightR[ch]) >>> Shift;
            wi = longint'(weightI[ch]) >>> Shift;
            sum = sum + wrapWord((stateR[ch] * wr - stateI[ch] * wi) >>> fracBits);
        end
        scaled = sum >>> (fracBits - (outWidth - 1));
        if (scaled > OutMax || scaled < OutMin) begin
            satCount++;
            scaled = (scaled > OutMax) ? OutMax : OutMin;
        end
        // Offset binary is the value moved up by half scale
        return outWidth'(scaled - OutMin);
    endfunction

    function automatic string testName(logic [2:0] id);
        case (id)
            3'd0: return "resetState";
            3'd1: return "randomStream";
            3'd2: return "allOnes";
            3'd3: return "extremes";
            3'd4: return "midRunReset";
            default: return "unknown";
        endcase
    endfunction

    // Model advances on the same edge as the DUT registers
    always @(posedge clkDS) begin
        cplxT pp;
        longint poleRe;
        longint poleIm;
        longint nr;
        longint ni;
        armed = 1'b1;
        curTest = testId;
        if (!rst) begin
            for (int ch = 0; ch < numChannels; ch++) begin
                stateR[ch] = 0;
                stateI[ch] = 0;
            end
            heldBits = '0;
            expQ.delete();
            expPcm = ZeroCode;
            expValid = 1'b0;
        end else begin
            for (int ch = 0; ch < numChannels; ch++) begin
                // Pole raised to osr with each product rescaled
                pp = poleToOsr(ch, osr, fracBits);
                poleRe = wrapWord(longint'(pp.re));
                poleIm = wrapWord(longint'(pp.im));
                nr = ((stateR[ch] * poleRe) >>> fracBits) - ((stateI[ch] * poleIm) >>> fracBits)
                   + lookup(ch, heldBits, 1'b0);
                ni = ((stateI[ch] * poleRe) >>> fracBits) + ((stateR[ch] * poleIm) >>> fracBits)
                   + lookup(ch, heldBits, 1'b1);
                stateR[ch] = wrapWord(nr);
                stateI[ch] = wrapWord(ni);
            end
            heldBits = sampleBits;
            expQ.push_back(outputCode());
            // Pipeline full once five results are queued
            if (expQ.size() == Latency) begin
                expPcm = expQ.pop_front();
                expValid = 1'b1;
            end else begin
                expPcm = ZeroCode;
                expValid = 1'b0;
            end
        end
    end

    // Outputs compared mid-cycle while stable
    always @(negedge clkDS) begin
        if (armed) begin
            checkCount++;
            if (valid !== expValid) begin
                errorCount++;
                $display("ERROR %s valid expected %0b actual %0b",
                         testName(curTest), expValid, valid);
            end
            if (pcmOut !== expPcm) begin
                errorCount++;
                $display("ERROR %s pcmOut expected %0h actual %0h",
                         testName(curTest), expPcm, pcmOut);
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/filterTb.sv
`timescale 1ns/1ps
`default_nettype none

module filterTb;
    localparam int numChannels = 4;
    localparam int osr = 8;
    localparam int fracBits = 14;
    localparam int outWidth = 14;
    localparam int ClkPeriod = 100;
    localparam int ResetCycles = 2;
    // Test lengths in clkDS cycles
    localparam int WarmupWords = 12;
    localparam int RandomWords = 2000;
    localparam int OnesWords = 400;
    localparam int ExtremeBlocks = 12;
    localparam int ExtremeLen = 40;
    localparam int MidRunWords = 300;
    localparam int DrainCycles = 10;
    localparam int TotalCycles = 2 * ResetCycles + WarmupWords + RandomWords + OnesWords
                               + ExtremeBlocks * ExtremeLen + 2 * MidRunWords + DrainCycles;
    localparam int MarginCycles = 100;

    logic clkDS;
    logic rst;
    logic [osr-1:0] sampleBits;
    logic [outWidth-1:0] pcmOut;
    logic valid;
    logic [2:0] testId;
    logic [31:0] rngState;
    int errorCount;
    int checkCount;
    int satCount;
    // Saturated model samples before the extremes test
    int satBefore;
    int stimErrors;

    reconFilterTop #(
        .numChannels(numChannels),
        .osr(osr),
        .fracBits(fracBits),
        .outWidth(outWidth)
    ) reconFilterTop_inst (
        .clkDS(clkDS),
        .rst(rst),
        .sampleBits(sampleBits),
        .pcmOut(pcmOut),
        .valid(valid)
    );

    filterChecker #(
        .numChannels(numChannels),
        .osr(osr),
        .fracBits(fracBits),
        .outWidth(outWidth)
    ) checkerInst (
        .clkDS(clkDS),
        .rst(rst),
        .sampleBits(sampleBits),
        .pcmOut(pcmOut),
        .valid(valid),
        .testId(testId),
        .errorCount(errorCount),
        .checkCount(checkCount),
        .satCount(satCount)
    );

    // 32-bit LCG step
    function automatic logic [31:0] lcgNext(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        clkDS = 1'b0;
        forever #(ClkPeriod / 2) clkDS = ~clkDS;
    end

    // Called at a falling edge or at time zero
    task automatic applyReset(int cycles);
        rst = 1'b0;
        repeat (cycles) @(negedge clkDS);
        rst = 1'b1;
    endtask

    task automatic driveRandom(int count);
        repeat (count) begin
            @(negedge clkDS);
            rngState = lcgNext(rngState);
            // Upper LCG bits
            sampleBits = rngState[31 -: osr];
        end
    endtask

    task automatic driveConstant(logic [osr-1:0] word, int count);
        repeat (count) begin
            @(negedge clkDS);
            sampleBits = word;
        end
    endtask

    initial begin
        rst = 1'b0;
        sampleBits = '0;
        testId = 3'd0;
        rngState = 32'h65da;
        stimErrors = 0;
        satBefore = 0;
        applyReset(ResetCycles);
        // Warm-up edges checked while a few words go in
        driveRandom(WarmupWords);
        testId = 3'd1;
        driveRandom(RandomWords);
        testId = 3'd2;
        driveConstant({osr{1'b1}}, OnesWords);
        // Long full-scale blocks push the sum into clipping
        testId = 3'd3;
        satBefore = satCount;
        for (int b = 0; b < ExtremeBlocks; b++) begin
            driveConstant((b % 2 == 0) ? {osr{1'b1}} : {osr{1'b0}}, ExtremeLen);
        end
        if (satCount == satBefore) begin
            stimErrors++;
            $display("Extremes test never drove the model into saturation");
        end
        testId = 3'd4;
        driveRandom(MidRunWords);
        applyReset(ResetCycles);
        driveRandom(MidRunWords);
        repeat (DrainCycles) @(negedge clkDS);
        $display("Errors: %0d  stimulus errors: %0d  checked cycles: %0d  saturated samples: %0d",
                 errorCount, stimErrors, checkCount, satCount);
        if (checkCount == 0) begin
            $display("No output cycle was checked");
        end
        if (errorCount == 0 && stimErrors == 0 && checkCount > 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog sized from the test lengths
    initial begin
        #((TotalCycles + MarginCycles) * ClkPeriod);
        $display("Timeout after %0d clkDS cycles, the stimulus never finished",
                 TotalCycles + MarginCycles);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
src/filterPkg.sv
src/sampleLut.sv
src/channelRecursion.sv
src/resultCombiner.sv
src/reconFilterTop.sv
tests/filterChecker.sv
tests/filterTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the filter testbench with Verilator, run it, and grep the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module filterTb -f verilog.f -o filterSim \
    > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/filterSim | tee sim.log

grep -qx "Finished with no errors" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see sim.log"; exit 1; }
